// ==== source/ctrl_bus_pkg.sv ====
/* Control register bus definitions
   Widths, vector types and response codes shared by the master and switch sides */
package ctrl_bus_pkg;

    // Address and data widths of the register bus
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // One strobe bit per data byte
    localparam int STRB_W = DATA_W / 8;

    // Bus vectors
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // Write and read response code
    typedef logic [1:0] resp_t;

    // Only OKAY is ever returned
    localparam resp_t RESP_OKAY = 2'b00;

endpackage

// ==== source/vswitch_pkg.sv ====
/* Virtual switch definitions
   Switch count and the address field that selects one switch for a read */
package vswitch_pkg;

    // Virtual switches hosted on the board
    localparam int NUM_SWITCHES = 4;

    // Bits needed to name one switch
    localparam int SW_IDX_W = $clog2(NUM_SWITCHES);

    typedef logic [SW_IDX_W-1:0] sw_idx_t;

    // Read select field starts at the lowest address bit
    // so the switch index is the address modulo the switch count
    localparam int SW_SEL_LSB = 0;

endpackage

// ==== source/switch_bus_if.sv ====
`timescale 1ns/1ps
/* Per-switch control bus bundle
   Shared address/data plus one valid/ready element per virtual switch */
interface switch_bus_if
    import ctrl_bus_pkg::*, vswitch_pkg::*;
;

    // Write path, same address/data/strobe seen by every switch
    addr_t                    aw_addr;
    data_t                    w_data;
    strb_t                    w_strb;
    logic [NUM_SWITCHES-1:0]  aw_valid;
    logic [NUM_SWITCHES-1:0]  aw_ready;
    logic [NUM_SWITCHES-1:0]  w_valid;
    logic [NUM_SWITCHES-1:0]  w_ready;
    logic [NUM_SWITCHES-1:0]  b_valid;
    logic [NUM_SWITCHES-1:0]  b_ready;

    // Read path, one address, per-switch handshakes and return data
    addr_t                    ar_addr;
    logic [NUM_SWITCHES-1:0]  ar_valid;
    logic [NUM_SWITCHES-1:0]  ar_ready;
    logic [NUM_SWITCHES-1:0]  r_valid;
    logic [NUM_SWITCHES-1:0]  r_ready;
    data_t                    r_data [NUM_SWITCHES];

    // Write fanout view
    modport write_side (
        output aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
        input  aw_ready, w_ready, b_valid
    );

    // Read router view
    modport read_side (
        output ar_addr, ar_valid, r_ready,
        input  ar_ready, r_valid, r_data
    );

endinterface

// ==== source/write_fanout.sv ====
`timescale 1ns/1ps
/* Write fanout
   Broadcasts master writes to every switch and answers with its own write response */
module write_fanout
    import ctrl_bus_pkg::*, vswitch_pkg::*;
(
    input  logic              M_AXI_ACLK,
    input  logic              M_AXI_ARESETN,
    input  addr_t             awaddr,
    input  logic              awvalid,
    input  data_t             wdata,
    input  strb_t             wstrb,
    input  logic              wvalid,
    input  logic              bready,
    output logic              awready,
    output logic              wready,
    output logic              bvalid,
    switch_bus_if.write_side  sw
);

    logic aw_any_ready;
    logic w_any_ready;
    logic aw_fire;
    logic w_fire;
    logic aw_done;
    logic w_done;
    logic both_done;

    // Same write reaches all switches
    assign sw.aw_addr  = awaddr;
    assign sw.w_data   = wdata;
    assign sw.w_strb   = wstrb;
    assign sw.aw_valid = {NUM_SWITCHES{awvalid}};
    assign sw.w_valid  = {NUM_SWITCHES{wvalid}};

    // Response ready follows the master
    // Switch responses left over while nothing is pending upstream are drained at once
    assign sw.b_ready = {NUM_SWITCHES{bready}} | (sw.b_valid & {NUM_SWITCHES{~bvalid}});

    // One ready switch is enough to take the write
    assign aw_any_ready = |sw.aw_ready;
    assign w_any_ready  = |sw.w_ready;

    // Master-side transfers
    assign aw_fire   = awready & awvalid;
    assign w_fire    = wready & wvalid;
    assign both_done = (aw_fire | aw_done) & (w_fire | w_done);

    // Address and data readies pulse for one cycle
    // Held off while a channel is already done or a response waits
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end
        else
        begin
            awready <= !awready && awvalid && wvalid && aw_any_ready && !aw_done && !bvalid;
            wready  <= !wready && awvalid && wvalid && w_any_ready && !w_done && !bvalid;
        end
    end

    // Track each half of the write, then raise the response
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            bvalid  <= 1'b0;
        end
        else if (both_done)
        begin
            // Address and data both in, response next cycle
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            bvalid  <= 1'b1;
        end
        else
        begin
            if (aw_fire)
                aw_done <= 1'b1;
            if (w_fire)
                w_done <= 1'b1;
            // Response holds until the master takes it
            if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

endmodule

// ==== source/read_router.sv ====
`timescale 1ns/1ps
/* Read router
   Sends each read to the switch named by the address and returns its data */
module read_router
    import ctrl_bus_pkg::*, vswitch_pkg::*;
(
    input  logic             M_AXI_ACLK,
    input  logic             M_AXI_ARESETN,
    input  addr_t            araddr,
    input  logic             arvalid,
    input  logic             rready,
    output logic             arready,
    output data_t            rdata,
    output logic             rvalid,
    switch_bus_if.read_side  sw
);

    // Read FSM states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_DATA,
        HOLD
    } rd_state_t;

    rd_state_t state;
    sw_idx_t   sel_idx;
    sw_idx_t   cur_idx;

    // Switch select field of the incoming address
    assign sel_idx = araddr[SW_SEL_LSB +: SW_IDX_W];

    // Address is visible to all, only valid is routed
    assign sw.ar_addr = araddr;

    // Registered data is valid for the whole hold state
    assign rvalid = (state == HOLD);

    // Route handshakes to one switch only
    always_comb
    begin
        sw.ar_valid = '0;
        sw.r_ready  = '0;
        // Address phase goes to the switch picked by the live address
        if (state == IDLE)
            sw.ar_valid[sel_idx] = arvalid;
        // Return path granted to the captured switch alone
        if (state == WAIT_DATA)
            sw.r_ready[cur_idx] = 1'b1;
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            state   <= IDLE;
            arready <= 1'b0;
            cur_idx <= '0;
            rdata   <= '0;
        end
        else
        begin
            // Address ready is a single-cycle pulse
            arready <= 1'b0;
            case (state)
                IDLE:
                begin
                    // Addressed switch took the request
                    if (arvalid && sw.ar_ready[sel_idx])
                    begin
                        arready <= 1'b1;
                        cur_idx <= sel_idx;
                        state   <= WAIT_DATA;
                    end
                end
                WAIT_DATA:
                begin
                    // Switch latency varies, wait for its data
                    if (sw.r_valid[cur_idx])
                    begin
                        rdata <= sw.r_data[cur_idx];
                        state <= HOLD;
                    end
                end
                HOLD:
                begin
                    // Data stays put until the master accepts it
                    if (rready)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

// ==== source/vswitch_ctrl_top.sv ====
`timescale 1ns/1ps
/* Virtual switch control splitter
   One master register port fanned out to four switches, writes broadcast, reads routed */
module vswitch_ctrl_top
    import ctrl_bus_pkg::*, vswitch_pkg::*;
(
    input  logic                     M_AXI_ACLK,
    input  logic                     M_AXI_ARESETN,
    // Master side
    input  addr_t                    m_awaddr,
    input  logic                     m_awvalid,
    input  data_t                    m_wdata,
    input  strb_t                    m_wstrb,
    input  logic                     m_wvalid,
    input  logic                     m_bready,
    input  addr_t                    m_araddr,
    input  logic                     m_arvalid,
    input  logic                     m_rready,
    output logic                     m_awready,
    output logic                     m_wready,
    output resp_t                    m_bresp,
    output logic                     m_bvalid,
    output logic                     m_arready,
    output data_t                    m_rdata,
    output resp_t                    m_rresp,
    output logic                     m_rvalid,
    // Switch side, one element per switch
    output addr_t                    sw_awaddr [NUM_SWITCHES],
    output logic [NUM_SWITCHES-1:0]  sw_awvalid,
    output data_t                    sw_wdata [NUM_SWITCHES],
    output strb_t                    sw_wstrb [NUM_SWITCHES],
    output logic [NUM_SWITCHES-1:0]  sw_wvalid,
    output logic [NUM_SWITCHES-1:0]  sw_bready,
    output addr_t                    sw_araddr [NUM_SWITCHES],
    output logic [NUM_SWITCHES-1:0]  sw_arvalid,
    output logic [NUM_SWITCHES-1:0]  sw_rready,
    input  logic [NUM_SWITCHES-1:0]  sw_awready,
    input  logic [NUM_SWITCHES-1:0]  sw_wready,
    input  logic [NUM_SWITCHES-1:0]  sw_bvalid,
    input  logic [NUM_SWITCHES-1:0]  sw_arready,
    input  logic [NUM_SWITCHES-1:0]  sw_rvalid,
    input  data_t                    sw_rdata [NUM_SWITCHES]
);

    switch_bus_if i_bus ();

    // No error responses on this bus
    assign m_bresp = RESP_OKAY;
    assign m_rresp = RESP_OKAY;

    // Per-switch handshakes straight to the ports
    assign sw_awvalid = i_bus.aw_valid;
    assign sw_wvalid  = i_bus.w_valid;
    assign sw_bready  = i_bus.b_ready;
    assign sw_arvalid = i_bus.ar_valid;
    assign sw_rready  = i_bus.r_ready;

    assign i_bus.aw_ready = sw_awready;
    assign i_bus.w_ready  = sw_wready;
    assign i_bus.b_valid  = sw_bvalid;
    assign i_bus.ar_ready = sw_arready;
    assign i_bus.r_valid  = sw_rvalid;
    assign i_bus.r_data   = sw_rdata;

    // Shared address and data copied onto every switch port
    for (genvar i = 0; i < NUM_SWITCHES; i++)
    begin : g_sw
        assign sw_awaddr[i] = i_bus.aw_addr;
        assign sw_wdata[i]  = i_bus.w_data;
        assign sw_wstrb[i]  = i_bus.w_strb;
        assign sw_araddr[i] = i_bus.ar_addr;
    end

    write_fanout i_write_fanout (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .awaddr        (m_awaddr),
        .awvalid       (m_awvalid),
        .wdata         (m_wdata),
        .wstrb         (m_wstrb),
        .wvalid        (m_wvalid),
        .bready        (m_bready),
        .awready       (m_awready),
        .wready        (m_wready),
        .bvalid        (m_bvalid),
        .sw            (i_bus.write_side)
    );

    read_router i_read_router (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .araddr        (m_araddr),
        .arvalid       (m_arvalid),
        .rready        (m_rready),
        .arready       (m_arready),
        .rdata         (m_rdata),
        .rvalid        (m_rvalid),
        .sw            (i_bus.read_side)
    );

endmodule

// ==== tests/vswitch_model.sv ====
`timescale 1ns/1ps
/* Behavioral virtual switch
   16-word register file with byte strobes, reads answered after a random delay */
module vswitch_model
    import ctrl_bus_pkg::*;
(
    input  logic   M_AXI_ACLK,
    input  logic   M_AXI_ARESETN,
    input  data_t  salt,
    input  logic   ready_en,
    input  addr_t  awaddr,
    input  logic   awvalid,
    output logic   awready,
    input  data_t  wdata,
    input  strb_t  wstrb,
    input  logic   wvalid,
    output logic   wready,
    output logic   bvalid,
    input  logic   bready,
    input  addr_t  araddr,
    input  logic   arvalid,
    output logic   arready,
    output logic   rvalid,
    output data_t  rdata,
    input  logic   rready
);

    data_t      regs [16];
    logic [3:0] rd_idx;
    logic [2:0] rd_wait;
    logic       rd_busy;

    // Write readies follow the testbench level so stalls can be forced
    assign awready = ready_en;
    assign wready  = ready_en;

    // One read at a time
    assign arready = !rd_busy;

    // Word lands whenever both valids are up, byte by byte under the strobes
    always @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
            bvalid <= 1'b0;
        end
        else if (awvalid && wvalid)
        begin
            for (int b = 0; b < STRB_W; b++)
                if (wstrb[b])
                    regs[awaddr[7:4]][b*8 +: 8] <= wdata[b*8 +: 8];
            bvalid <= 1'b1;
        end
        else if (bready)
            bvalid <= 1'b0;
    end

    // Read answered one to four cycles after the address
    always @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            rd_busy <= 1'b0;
            rd_idx  <= '0;
            rd_wait <= '0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end
        else if (!rd_busy)
        begin
            if (arvalid)
            begin
                rd_busy <= 1'b1;
                rd_idx  <= araddr[7:4];
                rd_wait <= 3'(($urandom % 4) + 1);
            end
        end
        else if (rvalid)
        begin
            // Data held for the router until it takes it
            if (rready)
            begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
            end
        end
        else if (rd_wait > 3'd1)
            rd_wait <= rd_wait - 3'd1;
        else
        begin
            rvalid <= 1'b1;
            rdata  <= regs[rd_idx] ^ salt;
        end
    end

endmodule

// ==== tests/vswitch_ctrl_properties.sv ====
`timescale 1ns/1ps
/* Master-side handshake assertions
   Bound into the write fanout and the read router */
module vswitch_ctrl_properties
    import ctrl_bus_pkg::*;
(
    input  logic   M_AXI_ACLK,
    input  logic   M_AXI_ARESETN,
    input  logic   addr_ready,
    input  logic   resp_valid,
    input  logic   resp_ready,
    input  data_t  resp_data
);

    // Response valid holds until the master takes it
    a_resp_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        resp_valid && !resp_ready |=> resp_valid)
        else $error("Response valid dropped before ready");

    // Response payload frozen while stalled
    a_data_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        resp_valid && !resp_ready |=> $stable(resp_data))
        else $error("Response data changed before ready");

    // Address ready is a one-cycle pulse
    a_ready_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        addr_ready |=> !addr_ready)
        else $error("Address ready high for two cycles");

endmodule

// While a response waits no new address or data is taken
bind write_fanout vswitch_ctrl_properties i_wr_props (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .addr_ready    (awready),
    .resp_valid    (bvalid),
    .resp_ready    (bready),
    .resp_data     (data_t'({awready, wready}))
);

bind read_router vswitch_ctrl_properties i_rd_props (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .addr_ready    (arready),
    .resp_valid    (rvalid),
    .resp_ready    (rready),
    .resp_data     (rdata)
);

// ==== tests/vswitch_ctrl_tb.sv ====
`timescale 1ns/1ps
/* Control splitter testbench
   Table of writes and reads run against four behavioral switches */
module vswitch_ctrl_tb
    import ctrl_bus_pkg::*, vswitch_pkg::*;
;

    localparam logic [2:0] OP_WR    = 3'd0;
    localparam logic [2:0] OP_RD    = 3'd1;
    localparam logic [2:0] OP_WR_BP = 3'd2;
    localparam logic [2:0] OP_RD_BP = 3'd3;
    localparam logic [2:0] OP_STALL = 3'd4;

    // Each switch scrambles its read data with its own salt
    localparam data_t SALTS [NUM_SWITCHES] = '{32'h1357_9bdf, 32'h2468_ace0,
                                               32'h0f0f_f0f0, 32'h8000_0001};

    typedef struct packed {
        logic [2:0] op;
        addr_t      addr;
        data_t      data;
        strb_t      strb;
        data_t      exp;
    } step_t;

    logic M_AXI_ACLK;
    logic M_AXI_ARESETN;
    addr_t m_awaddr;
    logic m_awvalid;
    data_t m_wdata;
    strb_t m_wstrb;
    logic m_wvalid;
    logic m_bready;
    addr_t m_araddr;
    logic m_arvalid;
    logic m_rready;
    logic m_awready;
    logic m_wready;
    resp_t m_bresp;
    logic m_bvalid;
    logic m_arready;
    data_t m_rdata;
    resp_t m_rresp;
    logic m_rvalid;
    addr_t sw_awaddr [NUM_SWITCHES];
    data_t sw_wdata [NUM_SWITCHES];
    strb_t sw_wstrb [NUM_SWITCHES];
    addr_t sw_araddr [NUM_SWITCHES];
    data_t sw_rdata [NUM_SWITCHES];
    logic [NUM_SWITCHES-1:0] sw_awvalid;
    logic [NUM_SWITCHES-1:0] sw_wvalid;
    logic [NUM_SWITCHES-1:0] sw_bready;
    logic [NUM_SWITCHES-1:0] sw_arvalid;
    logic [NUM_SWITCHES-1:0] sw_rready;
    logic [NUM_SWITCHES-1:0] sw_awready;
    logic [NUM_SWITCHES-1:0] sw_wready;
    logic [NUM_SWITCHES-1:0] sw_bvalid;
    logic [NUM_SWITCHES-1:0] sw_arready;
    logic [NUM_SWITCHES-1:0] sw_rvalid;
    logic [NUM_SWITCHES-1:0] sw_ready_en;

    step_t steps [$];
    int    step_idx;
    int    cycle_cnt;
    int    cycle_limit;

    vswitch_ctrl_top i_dut (.*);

    for (genvar k = 0; k < NUM_SWITCHES; k++)
    begin : g_sw
        vswitch_model i_sw (
            .M_AXI_ACLK    (M_AXI_ACLK),
            .M_AXI_ARESETN (M_AXI_ARESETN),
            .salt          (SALTS[k]),
            .ready_en      (sw_ready_en[k]),
            .awaddr        (sw_awaddr[k]),
            .awvalid       (sw_awvalid[k]),
            .awready       (sw_awready[k]),
            .wdata         (sw_wdata[k]),
            .wstrb         (sw_wstrb[k]),
            .wvalid        (sw_wvalid[k]),
            .wready        (sw_wready[k]),
            .bvalid        (sw_bvalid[k]),
            .bready        (sw_bready[k]),
            .araddr        (sw_araddr[k]),
            .arvalid       (sw_arvalid[k]),
            .arready       (sw_arready[k]),
            .rvalid        (sw_rvalid[k]),
            .rdata         (sw_rdata[k]),
            .rready        (sw_rready[k])
        );
    end

    always #50 M_AXI_ACLK = ~M_AXI_ACLK;

    // Run length bounded by the table size
    always @(posedge M_AXI_ACLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout after %0d cycles in step %0d", cycle_cnt, step_idx);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation did not finish in time");
        end
    end

    task automatic check_val(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("Mismatch %s got 0x%h expected 0x%h in step %0d", name, got, exp, step_idx);
            $display("RESULT: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic offer_write(input addr_t addr, input data_t data, input strb_t strb);
        m_awaddr  = addr;
        m_wdata   = data;
        m_wstrb   = strb;
        m_awvalid = 1'b1;
        m_wvalid  = 1'b1;
    endtask

    // Each valid drops after its own transfer edge
    task automatic finish_write();
        logic aw_pend;
        logic w_pend;
        logic aw_hit;
        logic w_hit;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        while (aw_pend || w_pend)
        begin
            aw_hit = aw_pend && m_awready;
            w_hit  = w_pend && m_wready;
            @(negedge M_AXI_ACLK);
            if (aw_hit)
            begin
                aw_pend   = 1'b0;
                m_awvalid = 1'b0;
            end
            if (w_hit)
            begin
                w_pend   = 1'b0;
                m_wvalid = 1'b0;
            end
        end
    endtask

    // Response refused for hold_cycles, then taken in one cycle
    task automatic take_bresp(input int hold_cycles);
        m_bready = (hold_cycles == 0);
        while (!m_bvalid)
            @(negedge M_AXI_ACLK);
        check_val("m_bresp", 32'(m_bresp), 32'h0);
        repeat (hold_cycles)
        begin
            @(negedge M_AXI_ACLK);
            check_val("m_bvalid", 32'(m_bvalid), 32'h1);
        end
        m_bready = 1'b1;
        @(negedge M_AXI_ACLK);
        check_val("m_bvalid", 32'(m_bvalid), 32'h0);
        // Response also taken from every switch
        check_val("sw_bvalid", 32'(sw_bvalid), 32'h0);
    endtask

    task automatic do_read(input addr_t addr, input data_t stored, input int hold_cycles);
        data_t held;
        m_araddr  = addr;
        m_arvalid = 1'b1;
        m_rready  = (hold_cycles == 0);
        while (!m_arready)
            @(negedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        m_arvalid = 1'b0;
        while (!m_rvalid)
            @(negedge M_AXI_ACLK);
        // Returned word carries the salt of the addressed switch
        check_val("m_rdata", m_rdata, stored ^ SALTS[addr % NUM_SWITCHES]);
        check_val("m_rresp", 32'(m_rresp), 32'h0);
        held = m_rdata;
        repeat (hold_cycles)
        begin
            @(negedge M_AXI_ACLK);
            check_val("m_rvalid", 32'(m_rvalid), 32'h1);
            check_val("m_rdata", m_rdata, held);
        end
        m_rready = 1'b1;
        @(negedge M_AXI_ACLK);
        check_val("m_rvalid", 32'(m_rvalid), 32'h0);
    endtask

    task automatic run_step(input step_t s);
        case (s.op)
            OP_WR:
            begin
                offer_write(s.addr, s.data, s.strb);
                finish_write();
                take_bresp(0);
            end
            OP_WR_BP:
            begin
                offer_write(s.addr, s.data, s.strb);
                finish_write();
                take_bresp(5);
            end
            OP_RD:
                do_read(s.addr, s.exp, 0);
            OP_RD_BP:
                do_read(s.addr, s.exp, 5);
            OP_STALL:
            begin
                // No switch takes the address so the master sees no ready
                sw_ready_en = '0;
                offer_write(s.addr, s.data, s.strb);
                repeat (6)
                begin
                    @(negedge M_AXI_ACLK);
                    check_val("m_awready", 32'(m_awready), 32'h0);
                end
                // One switch back is enough
                sw_ready_en[2] = 1'b1;
                finish_write();
                take_bresp(0);
                sw_ready_en = '1;
            end
        endcase
    endtask

    initial
    begin
        void'($urandom(32'h71b8fb0e));
        M_AXI_ACLK    = 1'b0;
        M_AXI_ARESETN = 1'b0;
        m_awaddr      = '0;
        m_awvalid     = 1'b0;
        m_wdata       = '0;
        m_wstrb       = '0;
        m_wvalid      = 1'b0;
        m_bready      = 1'b0;
        m_araddr      = '0;
        m_arvalid     = 1'b0;
        m_rready      = 1'b0;
        sw_ready_en   = '1;
        step_idx      = -1;
        // op, address, data, strobe, word expected in the switch
        steps.push_back(step_t'{OP_WR, 32'h10, 32'hcafe_f00d, 4'hf, 32'h0});
        steps.push_back(step_t'{OP_RD, 32'h10, 32'h0, 4'h0, 32'hcafe_f00d});
        steps.push_back(step_t'{OP_RD, 32'h11, 32'h0, 4'h0, 32'hcafe_f00d});
        steps.push_back(step_t'{OP_RD, 32'h12, 32'h0, 4'h0, 32'hcafe_f00d});
        steps.push_back(step_t'{OP_RD, 32'h13, 32'h0, 4'h0, 32'hcafe_f00d});
        steps.push_back(step_t'{OP_WR, 32'h20, 32'h1234_5678, 4'hf, 32'h0});
        // Bytes 0 and 2 only
        steps.push_back(step_t'{OP_WR, 32'h21, 32'haabb_ccdd, 4'h5, 32'h0});
        steps.push_back(step_t'{OP_RD, 32'h22, 32'h0, 4'h0, 32'h12bb_56dd});
        steps.push_back(step_t'{OP_RD, 32'h23, 32'h0, 4'h0, 32'h12bb_56dd});
        steps.push_back(step_t'{OP_WR, 32'h30, 32'hdead_beef, 4'h8, 32'h0});
        steps.push_back(step_t'{OP_RD, 32'h31, 32'h0, 4'h0, 32'hde00_0000});
        steps.push_back(step_t'{OP_WR_BP, 32'h50, 32'h0f1e_2d3c, 4'hf, 32'h0});
        steps.push_back(step_t'{OP_RD_BP, 32'h52, 32'h0, 4'h0, 32'h0f1e_2d3c});
        steps.push_back(step_t'{OP_STALL, 32'h40, 32'h0bad_cafe, 4'hf, 32'h0});
        steps.push_back(step_t'{OP_RD, 32'h40, 32'h0, 4'h0, 32'h0bad_cafe});
        steps.push_back(step_t'{OP_RD, 32'h41, 32'h0, 4'h0, 32'h0bad_cafe});
        steps.push_back(step_t'{OP_RD, 32'h42, 32'h0, 4'h0, 32'h0bad_cafe});
        steps.push_back(step_t'{OP_RD, 32'h43, 32'h0, 4'h0, 32'h0bad_cafe});
        steps.push_back(step_t'{OP_RD, 32'h20, 32'h0, 4'h0, 32'h12bb_56dd});
        cycle_limit = steps.size() * 20;
        repeat (3) @(negedge M_AXI_ACLK);
        M_AXI_ARESETN = 1'b1;
        check_val("m_awready", 32'(m_awready), 32'h0);
        check_val("m_wready", 32'(m_wready), 32'h0);
        check_val("m_bvalid", 32'(m_bvalid), 32'h0);
        check_val("m_arready", 32'(m_arready), 32'h0);
        check_val("m_rvalid", 32'(m_rvalid), 32'h0);
        check_val("m_rdata", m_rdata, 32'h0);
        foreach (steps[i])
        begin
            step_idx = i;
            run_step(steps[i]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
source/ctrl_bus_pkg.sv
source/vswitch_pkg.sv
source/switch_bus_if.sv
source/write_fanout.sv
source/read_router.sv
source/vswitch_ctrl_top.sv
tests/vswitch_model.sv
tests/vswitch_ctrl_properties.sv
tests/vswitch_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the control splitter testbench

sim:
	verilator --binary --timing --assert -f sim.f --top-module vswitch_ctrl_tb -Mdir obj_dir
	./obj_dir/Vvswitch_ctrl_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean
